/* Bender.yml */
package:
  name: rvCore

sources:
  - rvPkg.sv
  - ctrlIf.sv
  - control.sv
  - alu.sv
  - regFile.sv
  - signExtend.sv
  - pcUnit.sv
  - rvCore.sv
  - target: test
    files:
      - rvCoreTb.sv

/* alu.sv */
`default_nettype none

module alu import rvPkg::*; (
    ctrlIf.sink              ctrl,
    input  logic [XLEN-1:0]  rs1,
    input  logic [XLEN-1:0]  rs2,
    input  logic [XLEN-1:0]  pc,
    input  logic [XLEN-1:0]  imm,
    output logic [XLEN-1:0]  result,
    output logic             zero
);

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [4:0]      shamt;

    assign srcA  = ctrl.aluSrcA ? pc : rs1;
    assign srcB  = ctrl.aluSrcB ? imm : rs2;
    assign shamt = srcB[4:0]; // rv32 shifts use low five bits

    always_comb begin
        case (ctrl.aluControl)
            ALU_ADD:  result = srcA + srcB;
            ALU_SUB:  result = srcA - srcB;
            ALU_AND:  result = srcA & srcB;
            ALU_OR:   result = srcA | srcB;
            ALU_XOR:  result = srcA ^ srcB;
            ALU_SLL:  result = srcA << shamt;
            ALU_SRL:  result = srcA >> shamt;
            ALU_SRA:  result = $unsigned($signed(srcA) >>> shamt);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, srcA < srcB};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* control.sv */
`default_nettype none

module control import rvPkg::*; (
    input  logic         rst,
    input  opcodeT       op,       // instr[6:0]
    input  logic [2:0]   funct3,
    input  logic         funct7,   // instr[30]
    input  logic         zero,     // alu result is zero
    output logic         memWrite, // data memory write enable
    ctrlIf.source        ctrl
);

    logic  branch;     // conditional branch in flight
    logic  takeOnZero; // branch condition met when zero is high
    pcSrcT jumpSrc;    // next pc for non-branch instructions

    // funct3/funct7 to alu operation for OP and OP_IMM
    function automatic aluOpT aluDecode(
        input opcodeT     opc,
        input logic [2:0] f3,
        input logic       f7
    );
        aluOpT res;
        case (f3)
            3'd0: res = (opc == OP && f7) ? ALU_SUB : ALU_ADD; // addi has no sub form
            3'd1: res = ALU_SLL;
            3'd2: res = ALU_SLT;
            3'd3: res = ALU_SLTU;
            3'd4: res = ALU_XOR;
            3'd5: res = f7 ? ALU_SRA : ALU_SRL;
            3'd6: res = ALU_OR;
            default: res = ALU_AND;
        endcase
        return res;
    endfunction

    always_comb begin
        ctrl.regWrite   = 1'b0;
        ctrl.immSrc     = IMM_I;
        ctrl.resultSrc  = RES_ALU;
        ctrl.aluSrcA    = 1'b0;
        ctrl.aluSrcB    = 1'b0;
        ctrl.aluControl = ALU_ADD;
        memWrite        = 1'b0;
        branch          = 1'b0;
        jumpSrc         = PC_PLUS4;

        case (op)
            OP: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluDecode(op, funct3, funct7);
            end
            OP_IMM: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcB    = 1'b1;
                ctrl.aluControl = aluDecode(op, funct3, funct7);
            end
            LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcB   = 1'b1; // rs1 + offset
                ctrl.resultSrc = RES_MEM;
            end
            STORE: begin
                ctrl.immSrc  = IMM_S;
                ctrl.aluSrcB = 1'b1;
                memWrite     = 1'b1;
            end
            BRANCH: begin
                ctrl.immSrc = IMM_B;
                branch      = 1'b1;
                // compare op chosen so zero alone decides the branch
                case (funct3[2:1])
                    2'b10:   ctrl.aluControl = ALU_SLT;  // blt, bge
                    2'b11:   ctrl.aluControl = ALU_SLTU; // bltu, bgeu
                    default: ctrl.aluControl = ALU_SUB;  // beq, bne
                endcase
            end
            JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = RES_PC4;
                jumpSrc        = PC_TARGET;
            end
            JALR: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcB   = 1'b1;
                ctrl.resultSrc = RES_PC4;
                jumpSrc        = PC_ALU;
            end
            LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_U;
                ctrl.resultSrc = RES_IMM;
            end
            AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSrc   = IMM_U;
                ctrl.aluSrcA  = 1'b1; // pc + upper imm
                ctrl.aluSrcB  = 1'b1;
            end
            default: begin
                // unsupported opcode acts as a nop
            end
        endcase

        if (rst) begin
            ctrl.regWrite = 1'b0;
            memWrite      = 1'b0;
        end
    end

    // beq/bge/bgeu take on zero, bne/blt/bltu on nonzero
    assign takeOnZero = ~(funct3[0] ^ funct3[2]);

    always_comb begin
        if (rst) begin
            ctrl.pcSrc = PC_PLUS4;
        end else if (branch) begin
            ctrl.pcSrc = (zero == takeOnZero) ? PC_TARGET : PC_PLUS4;
        end else begin
            ctrl.pcSrc = jumpSrc;
        end
    end

endmodule

`default_nettype wire

/* ctrlIf.sv */
`default_nettype none

interface ctrlIf import rvPkg::*; ();

    logic      regWrite;
    immSrcT    immSrc;
    resultSrcT resultSrc;
    logic      aluSrcA;    // 0 = rs1, 1 = pc
    logic      aluSrcB;    // 0 = rs2, 1 = imm
    aluOpT     aluControl;
    pcSrcT     pcSrc;

    modport source (
        output regWrite, immSrc, resultSrc, aluSrcA, aluSrcB, aluControl, pcSrc
    );

    modport sink (
        input regWrite, immSrc, resultSrc, aluSrcA, aluSrcB, aluControl, pcSrc
    );

endinterface

`default_nettype wire

/* pcUnit.sv */
`default_nettype none

module pcUnit import rvPkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst,
    ctrlIf.sink              ctrl,
    input  logic [XLEN-1:0]  imm,
    input  logic [XLEN-1:0]  aluResult,
    output logic [XLEN-1:0]  pc,
    output logic [XLEN-1:0]  pcPlus4
);

    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] pcNext;

    assign pcPlus4  = pc + XLEN'(4);
    assign pcTarget = pc + imm; // branch and jal target

    always_comb begin
        case (ctrl.pcSrc)
            PC_TARGET: pcNext = pcTarget;
            PC_ALU:    pcNext = {aluResult[XLEN-1:1], 1'b0}; // jalr clears bit 0
            default:   pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile import rvPkg::*; (
    input  logic             clk,
    input  logic             rst,
    ctrlIf.sink              ctrl,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [4:0]       rdAddr,
    input  logic [XLEN-1:0]  aluResult,
    input  logic [XLEN-1:0]  readData,
    input  logic [XLEN-1:0]  pcPlus4,
    input  logic [XLEN-1:0]  imm,
    output logic [XLEN-1:0]  rs1,
    output logic [XLEN-1:0]  rs2
);

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] wbData; // write-back value

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM: wbData = readData;
            RES_PC4: wbData = pcPlus4;
            RES_IMM: wbData = imm;
            default: wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && rdAddr != 5'd0) begin // x0 stays zero
            regs[rdAddr] <= wbData;
        end
    end

    assign rs1 = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2 = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

/* rvCore.f */
rvPkg.sv
ctrlIf.sv
control.sv
alu.sv
regFile.sv
signExtend.sv
pcUnit.sv
rvCore.sv
rvCoreTb.sv

/* rvCore.sv */
`default_nettype none

module rvCore import rvPkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      instr,     // from instruction memory
    input  logic [XLEN-1:0]  readData,  // from data memory
    output logic [XLEN-1:0]  instrAddr,
    output logic [XLEN-1:0]  dataAddr,
    output logic [XLEN-1:0]  writeData,
    output logic             memWrite
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            zero;

    ctrlIf ctrlBus ();

    control uControl (
        .rst      (rst),
        .op       (opcodeT'(instr[6:0])),
        .funct3   (instr[14:12]),
        .funct7   (instr[30]),
        .zero     (zero),
        .memWrite (memWrite),
        .ctrl     (ctrlBus.source)
    );

    signExtend uSignExtend (
        .ctrl  (ctrlBus.sink),
        .instr (instr),
        .imm   (imm)
    );

    regFile uRegFile (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrlBus.sink),
        .rs1Addr   (instr[19:15]),
        .rs2Addr   (instr[24:20]),
        .rdAddr    (instr[11:7]),
        .aluResult (aluResult),
        .readData  (readData),
        .pcPlus4   (pcPlus4),
        .imm       (imm),
        .rs1       (rs1),
        .rs2       (rs2)
    );

    alu uAlu (
        .ctrl   (ctrlBus.sink),
        .rs1    (rs1),
        .rs2    (rs2),
        .pc     (pc),
        .imm    (imm),
        .result (aluResult),
        .zero   (zero)
    );

    pcUnit #(
        .RESET_PC (RESET_PC)
    ) uPcUnit (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrlBus.sink),
        .imm       (imm),
        .aluResult (aluResult),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    assign instrAddr = pc;
    assign dataAddr  = aluResult; // load/store address
    assign writeData = rs2;

endmodule

`default_nettype wire

/* rvCoreTb.sv */
`default_nettype none

module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC = 32'h0000_0400; // pc[9:2] is zero here

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] instr;
    logic [31:0] readData;
    logic [31:0] instrAddr;
    logic [31:0] dataAddr;
    logic [31:0] writeData;
    logic        memWrite;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    string       names [256];   // section of each program word
    logic [31:0] refPc;
    logic [31:0] refRegs [32];
    logic [31:0] refMem [256];  // model copy of data memory

    int          progLen = 0;
    int          slot = 0;      // next free store word
    string       section = "";
    integer      seed = 32'hb9a7;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit;
    logic        haltSeen = 1'b0;
    logic [31:0] haltPc;
    logic [31:0] expPc;
    logic [31:0] expAddr;
    logic [31:0] expData;
    logic        expWe;
    string       tname;

    rvCore #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .readData  (readData),
        .instrAddr (instrAddr),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // both memories answer combinationally
    assign instr    = imem[instrAddr[9:2]];
    assign readData = dmem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            dmem[dataAddr[9:2]] <= writeData;
        end
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23}; // sw only
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] fillWord(input int a);
        return (32'h9e37_79b9 * a) ^ (a << 20) ^ 32'hc3a5_0f1e;
    endfunction

    // rv32i alu semantics, alt selects sub/sra
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one instruction on the model state
    function automatic void refStep(output logic [31:0] ePc, output logic eWe,
                                    output logic [31:0] eAddr, output logic [31:0] eData);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] immU;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        wr;
        logic        taken;
        logic [2:0]  f3;
        ins    = imem[refPc[9:2]];
        f3     = ins[14:12];
        a      = refRegs[ins[19:15]];
        b      = refRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        immU   = {ins[31:12], 12'h000};
        ePc    = refPc;
        eWe    = 1'b0;
        eAddr  = '0;
        eData  = '0;
        res    = '0;
        wr     = 1'b0;
        nextPc = refPc + 32'd4;
        case (ins[6:0])
            7'h33: begin
                res = aluRef(f3, ins[30], a, b);
                wr  = 1'b1;
            end
            7'h13: begin
                res = aluRef(f3, f3 == 3'd5 && ins[30], a, immI); // only srai uses bit 30
                wr  = 1'b1;
            end
            7'h03: begin
                addr = a + immI;
                res  = refMem[addr[9:2]];
                wr   = 1'b1;
            end
            7'h23: begin
                addr  = a + immS;
                eWe   = 1'b1;
                eAddr = addr;
                eData = b;
                refMem[addr[9:2]] = b;
            end
            7'h63: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    nextPc = refPc + immB;
                end
            end
            7'h6f: begin
                res    = refPc + 32'd4;
                wr     = 1'b1;
                nextPc = refPc + immJ;
            end
            7'h67: begin
                res    = refPc + 32'd4;
                wr     = 1'b1;
                nextPc = (a + immI) & ~32'd1;
            end
            7'h37: begin
                res = immU;
                wr  = 1'b1;
            end
            7'h17: begin
                res = refPc + immU;
                wr  = 1'b1;
            end
            default: begin
            end
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            refRegs[ins[11:7]] = res;
        end
        refPc = nextPc;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[progLen]  = word;
        names[progLen] = section;
        progLen++;
    endtask

    task automatic loadImm(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12; // addi sign-extends its low part
        emit(uType(upper[19:0], rd, 7'h37));
        emit(iType(value[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    task automatic storeReg(input logic [4:0] rs);
        emit(sType(12'(slot * 4), rs, 5'd0));
        slot++;
    endtask

    task automatic buildProgram();
        logic [31:0] v3;
        int          iF3 [6] = '{0, 2, 3, 4, 6, 7};
        int          bF3 [6] = '{0, 1, 4, 5, 6, 7};
        int          pa [3]  = '{3, 3, 4};
        int          pb [3]  = '{3, 4, 3};
        section = "setup";
        emit(sType(12'd1016, 5'd0, 5'd0)); // store sits at RESET_PC while rst is high
        v3 = $random(seed);
        loadImm(5'd1, $random(seed));
        loadImm(5'd2, $random(seed));
        loadImm(5'd3, v3);
        loadImm(5'd4, v3 ^ 32'h8000_0000); // x4 differs from x3 only in sign
        section = "rtype";
        for (int p = 0; p < 2; p++) begin
            for (int f = 0; f < 8; f++) begin
                emit(rType(7'h00, p ? 5'd4 : 5'd2, p ? 5'd3 : 5'd1, 3'(f), 5'd11));
                storeReg(5'd11);
                if (f == 0 || f == 5) begin
                    emit(rType(7'h20, p ? 5'd4 : 5'd2, p ? 5'd3 : 5'd1, 3'(f), 5'd11));
                    storeReg(5'd11);
                end
            end
        end
        section = "itype";
        foreach (iF3[k]) begin
            emit(iType(12'($random(seed)), 5'd1, 3'(iF3[k]), 5'd11, 7'h13));
            storeReg(5'd11);
        end
        for (int r = 3; r < 5; r++) begin
            emit(iType({7'h00, 5'($random(seed))}, 5'(r), 3'd1, 5'd11, 7'h13));
            storeReg(5'd11);
            emit(iType({7'h00, 5'($random(seed))}, 5'(r), 3'd5, 5'd11, 7'h13));
            storeReg(5'd11);
            emit(iType({7'h20, 5'($random(seed))}, 5'(r), 3'd5, 5'd11, 7'h13));
            storeReg(5'd11);
        end
        section = "x0";
        emit(iType(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));
        emit(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        storeReg(5'd0);
        section = "lw";
        emit(iType(12'd0, 5'd0, 3'b010, 5'd10, 7'h03));    // word written above
        storeReg(5'd10);
        emit(iType(12'd1020, 5'd0, 3'b010, 5'd10, 7'h03)); // untouched fill word
        storeReg(5'd10);
        section = "branch";
        foreach (bF3[j]) begin
            foreach (pa[k]) begin
                emit(bType(13'd8, 5'(pb[k]), 5'(pa[k]), 3'(bF3[j])));
                emit(iType(12'd1, 5'd9, 3'd0, 5'd9, 7'h13)); // skipped when taken
            end
        end
        storeReg(5'd9);
        section = "jal";
        emit(jType(21'd8, 5'd5));
        emit(iType(12'd1, 5'd9, 3'd0, 5'd9, 7'h13));
        storeReg(5'd5);
        storeReg(5'd9);
        section = "jalr";
        emit(uType(20'd0, 5'd6, 7'h17));
        emit(iType(12'd13, 5'd6, 3'd0, 5'd7, 7'h67)); // odd target, bit 0 dropped
        emit(iType(12'd1, 5'd9, 3'd0, 5'd9, 7'h13));
        storeReg(5'd7);
        storeReg(5'd9);
        section = "upper";
        emit(uType(20'($random(seed)), 5'd8, 7'h37));
        storeReg(5'd8);
        emit(uType(20'($random(seed)), 5'd8, 7'h17));
        storeReg(5'd8);
        section = "halt";
        haltPc = RESET_PC + 32'(4 * progLen);
        emit(jType(21'd0, 5'd0)); // jump to itself
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        errors++;
        $display("mismatch %s expected %h actual %h", name, exp, act);
    endtask

    always @(negedge clk) begin
        if (rst) begin
            checks += 2;
            if (memWrite !== 1'b0) begin
                reportMismatch("reset memWrite", 32'd0, 32'(memWrite));
            end
            if (instrAddr !== RESET_PC) begin
                reportMismatch("reset pc", RESET_PC, instrAddr);
            end
        end else if (!haltSeen) begin
            refStep(expPc, expWe, expAddr, expData);
            tname = names[expPc[9:2]];
            checks += expWe ? 4 : 2;
            if (instrAddr !== expPc) begin
                reportMismatch({tname, " pc"}, expPc, instrAddr);
            end
            if (memWrite !== expWe) begin
                reportMismatch({tname, " memWrite"}, 32'(expWe), 32'(memWrite));
            end
            if (expWe && dataAddr !== expAddr) begin
                reportMismatch({tname, " dataAddr"}, expAddr, dataAddr);
            end
            if (expWe && writeData !== expData) begin
                reportMismatch({tname, " writeData"}, expData, writeData);
            end
            if (expPc == haltPc) begin
                haltSeen = 1'b1;
            end
        end
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            imem[i]   = jType(21'd0, 5'd0);
            names[i]  = "fill";
            dmem[i]   = fillWord(i);
            refMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        refPc = RESET_PC;
        buildProgram();
        limit = 2 * progLen + 20;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        while (!haltSeen && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!haltSeen) begin
            errors++;
            $display("timeout: program did not reach its halt address within %0d cycles", limit);
        end
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rvPkg.sv */
`default_nettype none

package rvPkg;

    localparam int XLEN = 32; // data and address width

    typedef enum logic [6:0] {
        OP     = 7'b0110011, // register-register alu
        OP_IMM = 7'b0010011, // register-immediate alu
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SLL  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SRA  = 4'b0111,
        ALU_SLT  = 4'b1000,
        ALU_SLTU = 4'b1001
    } aluOpT;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_U = 3'b011,
        IMM_J = 3'b100
    } immSrcT;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10, // link value for jal/jalr
        RES_IMM = 2'b11  // lui
    } resultSrcT;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_TARGET = 2'b01, // pc + imm, branches and jal
        PC_ALU    = 2'b10  // jalr
    } pcSrcT;

endpackage

`default_nettype wire

/* signExtend.sv */
`default_nettype none

module signExtend import rvPkg::*; (
    ctrlIf.sink              ctrl,
    input  logic [31:0]      instr,
    output logic [XLEN-1:0]  imm
);

    always_comb begin
        case (ctrl.immSrc)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset, bit 0 implied zero
            IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0}; // lui/auipc upper bits
            IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire
